// ==== Makefile ====
SIM = obj_dir/Vtb_smartnic_egress

$(SIM): tb.f $(wildcard hw/*.sv testbench/*.sv)
	verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_smartnic_egress \
		-Mdir obj_dir -o Vtb_smartnic_egress

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== hw/axis_egress_arb.sv ====
`default_nettype none

module axis_egress_arb (
    input  logic                     core_clk,
    input  logic                     core_rstn,
    input  smartnic_pkg::axis_beat_t in_beat [3],
    input  logic [2:0]               in_valid,
    output logic [2:0]               in_ready,
    output smartnic_pkg::axis_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);
    import smartnic_pkg::*;

    arb_state_t state;
    logic [1:0] ptr;       // round-robin start
    logic [1:0] grant_q;   // owner of the packet in flight
    logic [1:0] pick;
    logic [1:0] cur;
    logic       req;
    logic       can_load;
    logic       fire;

    function automatic logic [1:0] next_idx(input logic [1:0] idx);
        return (idx == 2'd2) ? 2'd0 : idx + 2'd1;
    endfunction

    // first valid input at or after ptr
    always_comb begin : rr_search
        logic [1:0] idx;
        pick = ptr;
        req  = 1'b0;
        idx  = ptr;
        for (int k = 0; k < 3; k++) begin
            if (!req && in_valid[idx]) begin
                pick = idx;
                req  = 1'b1;
            end
            idx = next_idx(idx);
        end
    end

    assign cur      = (state == in_packet) ? grant_q : pick;
    assign can_load = !out_valid || out_ready;  // empty or draining now
    assign fire     = in_valid[cur] && can_load;

    always_comb begin
        in_ready      = '0;
        in_ready[cur] = can_load && ((state == in_packet) || req);
    end

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            state   <= idle;
            ptr     <= 2'd0;
            grant_q <= 2'd0;
        end else if (fire) begin
            if (in_beat[cur].tlast) begin
                state <= idle;
                ptr   <= next_idx(cur);  // skip past the winner
            end else begin
                state   <= in_packet;
                grant_q <= cur;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            out_valid <= 1'b0;
        end else if (can_load) begin
            out_valid <= fire;
        end
    end

    always_ff @(posedge core_clk) begin
        if (fire) begin
            out_beat <= in_beat[cur];
        end
    end

endmodule

`default_nettype wire

// ==== hw/axis_egress_split.sv ====
`default_nettype none

module axis_egress_split (
    input  logic                     core_clk,
    input  logic                     core_rstn,
    input  smartnic_pkg::axis_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic                     egr_sel,
    output smartnic_pkg::axis_beat_t cmac_beat,
    output logic                     cmac_valid,
    input  logic                     cmac_ready,
    output smartnic_pkg::axis_beat_t host_beat,
    output logic                     host_valid,
    input  logic                     host_ready,
    output logic                     cmac_pkt,
    output logic                     host_pkt
);

    logic held;   // selection locked for current packet
    logic sel_q;
    logic sel;    // 1 = host
    logic fire;

    assign sel        = held ? sel_q : egr_sel;
    assign in_ready   = sel ? host_ready : cmac_ready;
    assign cmac_valid = in_valid && !sel;
    assign host_valid = in_valid && sel;
    assign fire       = in_valid && in_ready;

    assign cmac_pkt = fire && !sel && in_beat.tlast;
    assign host_pkt = fire && sel && in_beat.tlast;

    always_comb begin
        cmac_beat       = in_beat;
        cmac_beat.tuser = '0;  // cmac sees no metadata
    end

    always_comb begin
        host_beat                 = in_beat;
        host_beat.tuser.pid       = '0;
        host_beat.tuser.hdr_tlast = 1'b0;  // rss fields pass through
    end

    // lock the register value once the first beat is presented
    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            held  <= 1'b0;
            sel_q <= 1'b0;
        end else begin
            if (fire && in_beat.tlast) begin
                held <= 1'b0;
            end else if (in_valid) begin
                held <= 1'b1;
            end
            if (in_valid && !held) begin
                sel_q <= egr_sel;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/axis_port_steer.sv ====
`default_nettype none

module axis_port_steer (
    input  logic                     core_clk,
    input  logic                     core_rstn,
    input  smartnic_pkg::axis_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    output smartnic_pkg::axis_beat_t out_beat,
    output logic [1:0]               out_valid,
    input  logic [1:0]               out_ready
);
    import smartnic_pkg::*;

    port_t dest;
    logic  sop;      // next beat opens a packet
    logic  route_q;  // port held for the rest of the packet
    logic  route;
    logic  fire;

    assign dest  = (in_beat.tdest == port_loopback) ? in_beat.tid : in_beat.tdest;
    assign route = sop ? dest[0] : route_q;
    assign fire  = in_valid && in_ready;

    always_comb begin
        out_beat       = in_beat;
        out_beat.tdest = dest;  // loopback resolved
    end

    assign out_valid[0] = in_valid && !route;
    assign out_valid[1] = in_valid && route;
    assign in_ready     = out_ready[route];

    // a tdest change inside a packet does not move it
    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            sop     <= 1'b1;
            route_q <= 1'b0;
        end else if (fire) begin
            sop     <= in_beat.tlast;
            route_q <= route;
        end
    end

endmodule

`default_nettype wire

// ==== hw/smartnic_egress.sv ====
`default_nettype none

module smartnic_egress (
    input  logic                              core_clk,
    input  logic                              core_rstn,

    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  smartnic_pkg::apb_addr_t           paddr,
    input  smartnic_pkg::apb_data_t           pwdata,
    output smartnic_pkg::apb_data_t           prdata,
    output logic                              pready,
    output logic                              pslverr,

    input  smartnic_pkg::axis_beat_t          bypass_in [smartnic_pkg::num_cmac],
    input  logic [smartnic_pkg::num_cmac-1:0] bypass_valid,
    output logic [smartnic_pkg::num_cmac-1:0] bypass_ready,
    input  smartnic_pkg::axis_beat_t          app_in [smartnic_pkg::num_cmac],
    input  logic [smartnic_pkg::num_cmac-1:0] app_valid,
    output logic [smartnic_pkg::num_cmac-1:0] app_ready,
    output smartnic_pkg::axis_beat_t          cmac_out [smartnic_pkg::num_cmac],
    output logic [smartnic_pkg::num_cmac-1:0] cmac_valid,
    input  logic [smartnic_pkg::num_cmac-1:0] cmac_ready,
    output smartnic_pkg::axis_beat_t          host_out [smartnic_pkg::num_cmac],
    output logic [smartnic_pkg::num_cmac-1:0] host_valid,
    input  logic [smartnic_pkg::num_cmac-1:0] host_ready
);
    import smartnic_pkg::*;

    logic [num_cmac-1:0] egr_sel;
    logic [num_cmac-1:0] cmac_pkt;
    logic [num_cmac-1:0] host_pkt;

    axis_beat_t          steer_beat   [num_cmac];
    logic [1:0]          steer_valid  [num_cmac];  // [i][p]: app i to port p
    logic [1:0]          steer_ready  [num_cmac];
    axis_beat_t          arb_in_beat  [num_cmac][3];
    logic [2:0]          arb_in_valid [num_cmac];
    logic [2:0]          arb_in_ready [num_cmac];
    axis_beat_t          mux_beat     [num_cmac];
    logic [num_cmac-1:0] mux_valid;
    logic [num_cmac-1:0] mux_ready;

    smartnic_regs smartnic_regs_inst (
        .core_clk  (core_clk),
        .core_rstn (core_rstn),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cmac_pkt  (cmac_pkt),
        .host_pkt  (host_pkt),
        .egr_sel   (egr_sel)
    );

    for (genvar i = 0; i < num_cmac; i++) begin : g_port
        axis_port_steer steer_inst (
            .core_clk  (core_clk),
            .core_rstn (core_rstn),
            .in_beat   (app_in[i]),
            .in_valid  (app_valid[i]),
            .in_ready  (app_ready[i]),
            .out_beat  (steer_beat[i]),
            .out_valid (steer_valid[i]),
            .out_ready (steer_ready[i])
        );

        // merge inputs: bypass, then app streams steered from port 0 and 1
        assign arb_in_beat[i][0] = bypass_in[i];
        assign arb_in_beat[i][1] = steer_beat[0];
        assign arb_in_beat[i][2] = steer_beat[1];
        assign arb_in_valid[i]   = {steer_valid[1][i], steer_valid[0][i], bypass_valid[i]};
        assign bypass_ready[i]   = arb_in_ready[i][0];
        assign steer_ready[i]    = {arb_in_ready[1][i+1], arb_in_ready[0][i+1]};

        axis_egress_arb arb_inst (
            .core_clk  (core_clk),
            .core_rstn (core_rstn),
            .in_beat   (arb_in_beat[i]),
            .in_valid  (arb_in_valid[i]),
            .in_ready  (arb_in_ready[i]),
            .out_beat  (mux_beat[i]),
            .out_valid (mux_valid[i]),
            .out_ready (mux_ready[i])
        );

        axis_egress_split split_inst (
            .core_clk   (core_clk),
            .core_rstn  (core_rstn),
            .in_beat    (mux_beat[i]),
            .in_valid   (mux_valid[i]),
            .in_ready   (mux_ready[i]),
            .egr_sel    (egr_sel[i]),
            .cmac_beat  (cmac_out[i]),
            .cmac_valid (cmac_valid[i]),
            .cmac_ready (cmac_ready[i]),
            .host_beat  (host_out[i]),
            .host_valid (host_valid[i]),
            .host_ready (host_ready[i]),
            .cmac_pkt   (cmac_pkt[i]),
            .host_pkt   (host_pkt[i])
        );
    end

endmodule

`default_nettype wire

// ==== hw/smartnic_pkg.sv ====
`default_nettype none

package smartnic_pkg;

    localparam int num_cmac = 2;

    typedef logic [63:0] data_t;
    typedef logic [7:0]  keep_t;
    typedef logic [1:0]  port_t;

    // tdest code: return the packet to the port named in tid
    localparam port_t port_loopback = 2'd2;

    typedef struct packed {
        logic [15:0] pid;
        logic        rss_enable;
        logic [11:0] rss_entropy;
        logic        hdr_tlast;
    } tuser_meta_t;

    typedef struct packed {
        data_t       tdata;
        keep_t       tkeep;
        logic        tlast;
        port_t       tid;
        port_t       tdest;
        tuser_meta_t tuser;
    } axis_beat_t;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t reg_egr_sel   = 8'h00;  // bit i: port i to host
    localparam apb_addr_t reg_cnt_cmac0 = 8'h04;
    localparam apb_addr_t reg_cnt_cmac1 = 8'h08;
    localparam apb_addr_t reg_cnt_host0 = 8'h0C;
    localparam apb_addr_t reg_cnt_host1 = 8'h10;

    typedef enum logic {
        idle,
        in_packet
    } arb_state_t;

endpackage

`default_nettype wire

// ==== hw/smartnic_regs.sv ====
`default_nettype none

module smartnic_regs (
    input  logic                              core_clk,
    input  logic                              core_rstn,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  smartnic_pkg::apb_addr_t           paddr,
    input  smartnic_pkg::apb_data_t           pwdata,
    output smartnic_pkg::apb_data_t           prdata,
    output logic                              pready,
    output logic                              pslverr,
    input  logic [smartnic_pkg::num_cmac-1:0] cmac_pkt,
    input  logic [smartnic_pkg::num_cmac-1:0] host_pkt,
    output logic [smartnic_pkg::num_cmac-1:0] egr_sel
);
    import smartnic_pkg::*;

    apb_data_t cnt_cmac [num_cmac];
    apb_data_t cnt_host [num_cmac];
    apb_data_t rd_data;
    logic      rd_err;
    logic      access;
    logic      wr_en;

    assign access = psel && penable && !pready;  // first access cycle
    assign wr_en  = psel && penable && pready && pwrite && (paddr == reg_egr_sel);

    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (paddr)
            reg_egr_sel:   rd_data = apb_data_t'(egr_sel);
            reg_cnt_cmac0: rd_data = cnt_cmac[0];
            reg_cnt_cmac1: rd_data = cnt_cmac[1];
            reg_cnt_host0: rd_data = cnt_host[0];
            reg_cnt_host1: rd_data = cnt_host[1];
            default:       rd_err  = 1'b1;
        endcase
    end

    // one wait state, response comes up in the second access cycle
    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            pready  <= access;
            pslverr <= access && (pwrite ? (paddr != reg_egr_sel) : rd_err);
        end
    end

    always_ff @(posedge core_clk) begin
        if (access) begin
            prdata <= pwrite ? '0 : rd_data;
        end
    end

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            egr_sel <= '0;  // all ports to cmac
        end else if (wr_en) begin
            egr_sel <= pwdata[num_cmac-1:0];
        end
    end

    always_ff @(posedge core_clk) begin
        if (!core_rstn) begin
            for (int i = 0; i < num_cmac; i++) begin
                cnt_cmac[i] <= '0;
                cnt_host[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_cmac; i++) begin
                if (cmac_pkt[i]) begin
                    cnt_cmac[i] <= cnt_cmac[i] + 1'b1;  // wraps
                end
                if (host_pkt[i]) begin
                    cnt_host[i] <= cnt_host[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/smartnic_pkg.sv
hw/smartnic_regs.sv
hw/axis_port_steer.sv
hw/axis_egress_arb.sv
hw/axis_egress_split.sv
hw/smartnic_egress.sv
testbench/tb_smartnic_egress.sv

// ==== testbench/tb_smartnic_egress.sv ====
`default_nettype none

module tb_smartnic_egress;
    timeunit 1ns;
    timeprecision 100ps;
    import smartnic_pkg::*;

    localparam int burst_pkts = 6;
    localparam int max_len    = 8;
    localparam int timeout_ns = (3 * burst_pkts * max_len * 6 + 1000) * 100;  // slow random ready

    logic                core_clk = 1'b0;
    logic                core_rstn;
    logic                psel;
    logic                penable;
    logic                pwrite;
    apb_addr_t           paddr;
    apb_data_t           pwdata;
    apb_data_t           prdata;
    logic                pready;
    logic                pslverr;
    axis_beat_t          bypass_in [num_cmac];
    logic [num_cmac-1:0] bypass_valid;
    logic [num_cmac-1:0] bypass_ready;
    axis_beat_t          app_in [num_cmac];
    logic [num_cmac-1:0] app_valid;
    logic [num_cmac-1:0] app_ready;
    axis_beat_t          cmac_out [num_cmac];
    logic [num_cmac-1:0] cmac_valid;
    logic [num_cmac-1:0] cmac_ready;
    axis_beat_t          host_out [num_cmac];
    logic [num_cmac-1:0] host_valid;
    logic [num_cmac-1:0] host_ready;

    logic [31:0] rng = 32'h92491ed0;
    axis_beat_t  exp_q [4][$];  // bypass 0 and 1 then app 0 and 1
    axis_beat_t  out_q [4][$];  // cmac at 2*port and host right after
    int          pkt_cnt [4];
    int          seq [4];
    logic [3:0]  stall;
    logic        rand_ready;

    smartnic_egress smartnic_egress_inst (.*);

    always #50 core_clk = ~core_clk;

    always @(negedge core_clk) begin
        logic [31:0] r;
        r = rand_ready ? next_rand() : '1;
        for (int p = 0; p < num_cmac; p++) begin
            cmac_ready[p] = r[2*p] && !stall[2*p];
            host_ready[p] = r[2*p+1] && !stall[2*p+1];
        end
    end

    always @(posedge core_clk) begin
        for (int p = 0; p < num_cmac; p++) begin
            if (cmac_valid[p] && cmac_ready[p]) begin
                out_q[2*p].push_back(cmac_out[p]);
                pkt_cnt[2*p] += int'(cmac_out[p].tlast);
            end
            if (host_valid[p] && host_ready[p]) begin
                out_q[2*p+1].push_back(host_out[p]);
                pkt_cnt[2*p+1] += int'(host_out[p].tlast);
            end
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic src_fire(input int key);
        if (key < 2) begin
            return bypass_valid[key] && bypass_ready[key];
        end
        return app_valid[key-2] && app_ready[key-2];
    endfunction

    task automatic check_equal(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(negedge core_clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge core_clk);
        penable = 1'b1;
        do @(posedge core_clk); while (!pready);
        data = prdata;
        err  = pslverr;
        @(negedge core_clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(negedge core_clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge core_clk);
        penable = 1'b1;
        do @(posedge core_clk); while (!pready);
        check_equal("pslverr", pslverr, 0);
        @(negedge core_clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic send_packet(input int key, input int len, input port_t tid, input port_t tdest);
        axis_beat_t  b;
        logic [31:0] r;
        for (int i = 0; i < len; i++) begin
            @(negedge core_clk);
            r       = next_rand();
            b.tdata = {8'(key), 8'(seq[key]), 16'(i), next_rand()};  // source tag then packet and beat
            b.tkeep = 8'hff;
            b.tlast = (i == len - 1);
            b.tid   = tid;
            b.tdest = tdest;
            b.tuser = r[29:0];
            if (key < 2) begin
                bypass_in[key]    = b;
                bypass_valid[key] = 1'b1;
            end else begin
                app_in[key-2]    = b;
                app_valid[key-2] = 1'b1;
            end
            if (key >= 2 && tdest == port_loopback) begin
                b.tdest = tid;  // loopback leaves as the source port
            end
            exp_q[key].push_back(b);
            do @(posedge core_clk); while (!src_fire(key));
        end
        seq[key]++;
    endtask

    task automatic send_burst(input int key, input int n, input port_t tid, input port_t tdest,
                              input int len);
        for (int k = 0; k < n; k++) begin
            send_packet(key, (len > 0) ? len : 1 + int'(next_rand() % max_len), tid, tdest);
        end
        @(negedge core_clk);
        if (key < 2) begin
            bypass_valid[key] = 1'b0;
        end else begin
            app_valid[key-2] = 1'b0;
        end
    endtask

    task automatic expect_packet(input int o, input int key);
        axis_beat_t got;
        axis_beat_t exp;
        string      sig;
        sig = $sformatf("%s_out[%0d]", (o % 2) ? "host" : "cmac", o / 2);
        do begin
            while (out_q[o].size() == 0) @(posedge core_clk);
            got = out_q[o].pop_front();
            exp = exp_q[key].pop_front();
            if (o % 2 == 0) begin
                exp.tuser = '0;
            end else begin
                exp.tuser.pid       = '0;
                exp.tuser.hdr_tlast = 1'b0;
            end
            check_equal({sig, ".tdata"}, got.tdata, exp.tdata);
            check_equal({sig, ".tuser"}, got.tuser, exp.tuser);
            check_equal(sig, got, exp);
        end while (!exp.tlast);
    endtask

    task automatic test_reset();
        apb_data_t d;
        logic      err;
        check_equal("cmac_valid", cmac_valid, 0);
        check_equal("host_valid", host_valid, 0);
        for (int i = 0; i <= 4; i++) begin
            apb_read(apb_addr_t'(4 * i), d, err);
            check_equal("prdata", d, 0);
            check_equal("pslverr", err, 0);
        end
        apb_read(8'h20, d, err);
        check_equal("prdata", d, 0);
        check_equal("pslverr", err, 1);
    endtask

    task automatic test_steering();
        send_burst(2, 1, 2'd0, 2'd1, 0);
        expect_packet(2, 2);
        send_burst(3, 1, 2'd0, port_loopback, 0);
        expect_packet(0, 3);
        send_burst(2, 1, 2'd1, port_loopback, 0);
        expect_packet(2, 2);
    endtask

    task automatic test_host_select();
        apb_write(reg_egr_sel, 32'h1);
        send_burst(0, 2, 2'd0, 2'd0, 0);
        expect_packet(1, 0);
        expect_packet(1, 0);
        send_burst(1, 1, 2'd1, 2'd1, 0);
        expect_packet(2, 1);
    endtask

    task automatic test_switch_held();
        stall[2] = 1'b1;  // cmac_ready[1] low
        fork
            send_burst(1, 1, 2'd1, 2'd1, 4);
            begin
                do @(posedge core_clk); while (!cmac_valid[1]);
                apb_write(reg_egr_sel, 32'h3);
                stall[2] = 1'b0;
            end
        join
        expect_packet(2, 1);
        send_burst(1, 1, 2'd1, 2'd1, 3);
        expect_packet(3, 1);
    endtask

    task automatic test_round_robin();
        int keys [3];
        int start;
        keys       = '{0, 2, 3};  // arbiter inputs of port 0
        start      = 1;  // pointer left past bypass 0 by the host select packets
        rand_ready = 1'b1;
        fork
            send_burst(0, burst_pkts, 2'd0, 2'd0, 0);
            send_burst(2, burst_pkts, 2'd0, 2'd0, 0);
            send_burst(3, burst_pkts, 2'd0, port_loopback, 0);
        join
        for (int k = 0; k < 3 * burst_pkts; k++) begin
            expect_packet(1, keys[(start + k) % 3]);
        end
        rand_ready = 1'b0;
    endtask

    task automatic test_counters();
        apb_addr_t addr [4];
        apb_data_t d;
        logic      err;
        addr = '{reg_cnt_cmac0, reg_cnt_host0, reg_cnt_cmac1, reg_cnt_host1};
        for (int o = 0; o < 4; o++) begin
            apb_read(addr[o], d, err);
            check_equal($sformatf("prdata[0x%02h]", addr[o]), d, pkt_cnt[o]);
        end
    endtask

    initial begin
        core_rstn    = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        bypass_in    = '{default: '0};
        bypass_valid = '0;
        app_in       = '{default: '0};
        app_valid    = '0;
        cmac_ready   = '1;
        host_ready   = '1;
        stall        = '0;
        rand_ready   = 1'b0;
        repeat (10) @(negedge core_clk);
        core_rstn = 1'b1;
        test_reset();
        test_steering();
        test_host_select();
        test_switch_held();
        test_round_robin();
        test_counters();
        $display("Simulation passed");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired before all packets were seen");
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

`default_nettype wire
